//--- me_defines.svh
`ifndef ME_DEFINES_SVH
`define ME_DEFINES_SVH

`define ME_WORD_W       32  // host fifo word
`define ME_RES_W        27  // result word as held by a unit
`define ME_N_WORDS      8   // words per result
`define ME_N_UNITS      4
`define ME_UNIT_W       2
`define ME_IDX_W        3
`define ME_ADDR_W       4   // result store holds 16 results
`define ME_E_WORDS      8   // exponent words following LOAD_ERAM
`define ME_FIFO_WIDTHU  5

// command word fields, msb first
`define ME_CMD_W        6
`define ME_UNIT_FLD_W   5
`define ME_ADDR_FLD_W   20

`define ME_RSP_W        4
`define ME_RSP_ERAM     4'h1
`define ME_RSP_SETADDR  4'h2
`define ME_RSP_READ     4'h4

`endif

//--- me_host_pkg.sv
`include "me_defines.svh"

package me_host_pkg;

    typedef logic [`ME_WORD_W-1:0] host_word_t;

    // one-hot command field
    // LOAD_TRAM and START_MULT have no engine behind them and fall to unknown
    typedef enum logic [`ME_CMD_W-1:0] {
        CMD_LOAD_ERAM   = 6'b000001,
        CMD_SET_ADDR    = 6'b000010,
        CMD_LOAD_TRAM   = 6'b000100,
        CMD_READ_RESULT = 6'b001000,
        CMD_START_MULT  = 6'b100000
    } host_cmd_e;

    typedef struct packed {
        host_cmd_e                  cmd;
        logic                       load_prev;  // preload from store, else blank
        logic [`ME_UNIT_FLD_W-1:0]  unit;
        logic [`ME_ADDR_FLD_W-1:0]  addr;
    } host_cmd_t;

    typedef logic [`ME_RSP_W-1:0] rsp_code_t;

endpackage

//--- me_store_pkg.sv
`include "me_defines.svh"

package me_store_pkg;

    typedef logic [`ME_RES_W-1:0]  res_word_t;
    typedef logic [`ME_ADDR_W-1:0] store_addr_t;
    typedef logic [`ME_UNIT_W-1:0] unit_id_t;
    typedef logic [`ME_IDX_W-1:0]  word_idx_t;

    typedef enum logic [2:0] {
        XFER_NONE,
        XFER_SWAP_OUT,      // unit buffer -> store at the unit's address
        XFER_PRELOAD_COPY,  // store at req addr -> unit buffer
        XFER_PRELOAD_BLANK, // word 0 = 1, rest 0
        XFER_STREAM         // store at req addr -> engine
    } xfer_e;

    typedef struct packed {
        xfer_e       kind;
        unit_id_t    unit;
        store_addr_t addr;
    } xfer_req_t;

endpackage

//--- me_command_engine.sv
`timescale 1ns/1ps
`include "me_defines.svh"

module me_command_engine (
    input  logic                        clk,
    input  logic                        ctrl_reset_n,
    input  me_host_pkg::host_word_t     fifo_datai,
    input  logic                        fifo_empty,
    input  logic [`ME_FIFO_WIDTHU:0]    fifo_usedw_in,
    output logic                        fifo_rden,
    output me_host_pkg::host_word_t     fifo_datao,
    output logic                        fifo_wren,
    input  logic                        fifo_full,
    input  logic [`ME_FIFO_WIDTHU:0]    fifo_usedw_out,
    output me_store_pkg::xfer_req_t     xfer_req,
    input  logic                        store_idle,
    input  me_store_pkg::res_word_t     stream_data,
    input  logic                        stream_valid,
    output logic                        addr_wren,
    output me_store_pkg::unit_id_t      addr_unit,
    output me_store_pkg::store_addr_t   addr_data
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INTERPRET,
        ST_SWAP,
        ST_PRELOAD,
        ST_PAYLOAD,
        ST_RESPOND,
        ST_STREAM
    } state_e;

    state_e                         state_q, state_d;
    me_host_pkg::host_cmd_t         cmd_in;
    me_host_pkg::host_cmd_t         cmd_q, cmd_d;
    me_host_pkg::rsp_code_t         rsp_code;
    me_host_pkg::host_word_t        datao_q, datao_d;
    me_store_pkg::xfer_req_t        xfer_q, xfer_d;
    logic                           rden_q, rden_d;
    logic                           wren_q, wren_d;
    logic                           delay_q, delay_d;
    logic                           addr_wren_q, addr_wren_d;
    logic [$clog2(`ME_E_WORDS)-1:0] pay_cnt_q, pay_cnt_d;
    logic                           pay_done_q, pay_done_d;
    logic                           rfifo_pop;
    logic                           wfifo_has_room;
    logic                           store_ready;

    function automatic me_store_pkg::xfer_req_t mk_xfer(
        input me_store_pkg::xfer_e    kind,
        input me_host_pkg::host_cmd_t c
    );
        me_store_pkg::xfer_req_t r;
        r.kind = kind;
        r.unit = me_store_pkg::unit_id_t'(c.unit);   // upper unit bits unused here
        r.addr = me_store_pkg::store_addr_t'(c.addr);
        return r;
    endfunction

    assign cmd_in         = me_host_pkg::host_cmd_t'(fifo_datai);
    assign rfifo_pop      = rden_q & ~fifo_empty & (fifo_usedw_in != '0);
    // header plus the whole result must fit before streaming starts
    assign wfifo_has_room = (fifo_usedw_out + `ME_N_WORDS + 1) < (1 << `ME_FIFO_WIDTHU);
    assign store_ready    = store_idle & ~delay_q;   // store lags the request by a cycle
    assign rsp_code       = (cmd_q.cmd == me_host_pkg::CMD_LOAD_ERAM) ? `ME_RSP_ERAM
                                                                       : `ME_RSP_SETADDR;

    always_comb begin
        state_d     = state_q;
        cmd_d       = cmd_q;
        datao_d     = datao_q;
        xfer_d      = '0;       // request is a one-cycle pulse
        rden_d      = rden_q;
        wren_d      = wren_q;
        delay_d     = 1'b0;
        addr_wren_d = 1'b0;
        pay_cnt_d   = pay_cnt_q;
        pay_done_d  = pay_done_q;
        case (state_q)
            ST_IDLE: begin
                rden_d = 1'b1;
                wren_d = 1'b0;
                if (rfifo_pop) begin
                    rden_d  = 1'b0;
                    state_d = ST_INTERPRET;
                end
            end
            ST_INTERPRET: begin
                cmd_d = cmd_in;  // fifo_datai moves once payload pops start
                case (cmd_in.cmd)
                    me_host_pkg::CMD_LOAD_ERAM, me_host_pkg::CMD_SET_ADDR: begin
                        xfer_d     = mk_xfer(me_store_pkg::XFER_SWAP_OUT, cmd_in);
                        delay_d    = 1'b1;
                        pay_cnt_d  = '0;
                        pay_done_d = (cmd_in.cmd == me_host_pkg::CMD_SET_ADDR);
                        rden_d     = (cmd_in.cmd == me_host_pkg::CMD_LOAD_ERAM);
                        state_d    = ST_SWAP;
                    end
                    me_host_pkg::CMD_READ_RESULT: begin
                        if (wfifo_has_room) begin
                            xfer_d  = mk_xfer(me_store_pkg::XFER_STREAM, cmd_in);
                            delay_d = 1'b1;
                            wren_d  = 1'b1;
                            datao_d = {`ME_RSP_READ, 8'(`ME_N_WORDS), cmd_in.addr};
                            state_d = ST_STREAM;
                        end
                    end
                    default: begin
                        state_d = ST_IDLE;  // unknown, dropped silently
                    end
                endcase
            end
            ST_SWAP: begin
                if (store_ready) begin
                    // old result is out, take the new address and preload
                    addr_wren_d = 1'b1;
                    xfer_d      = mk_xfer(cmd_q.load_prev ? me_store_pkg::XFER_PRELOAD_COPY
                                                          : me_store_pkg::XFER_PRELOAD_BLANK,
                                          cmd_q);
                    delay_d     = 1'b1;
                    state_d     = ST_PRELOAD;
                end
            end
            ST_PRELOAD: begin
                if (store_ready) begin
                    state_d = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (pay_done_q) begin
                    wren_d  = 1'b1;
                    datao_d = {rsp_code, {(`ME_WORD_W-`ME_RSP_W){1'b0}}};
                    state_d = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (~fifo_full) begin  // held until accepted
                    wren_d  = 1'b0;
                    state_d = ST_IDLE;
                end
            end
            ST_STREAM: begin
                if (delay_q) begin
                    wren_d = 1'b0;     // header went out last cycle
                end else begin
                    wren_d = stream_valid;
                    if (stream_valid) begin
                        datao_d = {{(`ME_WORD_W-`ME_RES_W){1'b0}}, stream_data};
                    end
                    if (store_idle) begin
                        state_d = ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase

        // exponent payload is discarded but must still be drained
        if (!pay_done_q && rfifo_pop &&
            (state_q inside {ST_SWAP, ST_PRELOAD, ST_PAYLOAD})) begin
            if (pay_cnt_q == `ME_E_WORDS - 1) begin
                rden_d     = 1'b0;
                pay_done_d = 1'b1;
            end else begin
                pay_cnt_d = pay_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge ctrl_reset_n) begin
        if (~ctrl_reset_n) begin
            state_q     <= ST_IDLE;
            xfer_q      <= '0;
            rden_q      <= 1'b0;
            wren_q      <= 1'b0;
            delay_q     <= 1'b0;
            addr_wren_q <= 1'b0;
            pay_cnt_q   <= '0;
            pay_done_q  <= 1'b1;
        end else begin
            state_q     <= state_d;
            xfer_q      <= xfer_d;
            rden_q      <= rden_d;
            wren_q      <= wren_d;
            delay_q     <= delay_d;
            addr_wren_q <= addr_wren_d;
            pay_cnt_q   <= pay_cnt_d;
            pay_done_q  <= pay_done_d;
        end
    end

    always_ff @(posedge clk) begin
        cmd_q   <= cmd_d;
        datao_q <= datao_d;
    end

    assign fifo_rden  = rden_q;
    assign fifo_wren  = wren_q;
    assign fifo_datao = datao_q;
    assign xfer_req   = xfer_q;
    assign addr_wren  = addr_wren_q;
    assign addr_unit  = me_store_pkg::unit_id_t'(cmd_q.unit);
    assign addr_data  = me_store_pkg::store_addr_t'(cmd_q.addr);

endmodule

//--- me_result_store.sv
`timescale 1ns/1ps
`include "me_defines.svh"

module me_result_store (
    input  logic                        clk,
    input  logic                        ctrl_reset_n,
    input  me_store_pkg::xfer_req_t     xfer_req,
    output logic                        store_idle,
    input  me_store_pkg::store_addr_t   unit_addr,
    output me_store_pkg::unit_id_t      bank_unit,
    output me_store_pkg::word_idx_t     bank_idx,
    output logic                        bank_rden,
    output logic                        bank_wren,
    output me_store_pkg::res_word_t     bank_wdata,
    input  me_store_pkg::res_word_t     bank_rdata,
    output me_store_pkg::res_word_t     stream_data,
    output logic                        stream_valid
);

    // results laid out as {address, word index}
    me_store_pkg::res_word_t    mem [(1 << `ME_ADDR_W) * `ME_N_WORDS];
    me_store_pkg::res_word_t    mem_q;
    me_store_pkg::xfer_req_t    cur_q;
    me_store_pkg::word_idx_t    issue_idx_q, ridx_q;
    logic                       busy_q;
    logic                       issue_q;    // read strobes going out
    logic                       rvalid_q;   // read data arriving
    logic                       is_swap, is_copy, is_blank, is_stream;

    assign is_swap   = cur_q.kind == me_store_pkg::XFER_SWAP_OUT;
    assign is_copy   = cur_q.kind == me_store_pkg::XFER_PRELOAD_COPY;
    assign is_blank  = cur_q.kind == me_store_pkg::XFER_PRELOAD_BLANK;
    assign is_stream = cur_q.kind == me_store_pkg::XFER_STREAM;

    always_ff @(posedge clk or negedge ctrl_reset_n) begin
        if (~ctrl_reset_n) begin
            cur_q       <= '0;
            busy_q      <= 1'b0;
            issue_q     <= 1'b0;
            rvalid_q    <= 1'b0;
            issue_idx_q <= '0;
            ridx_q      <= '0;
        end else begin
            rvalid_q <= issue_q;
            ridx_q   <= issue_idx_q;
            if (issue_q) begin
                issue_idx_q <= issue_idx_q + 1'b1;  // wraps back to 0 after the last word
                if (issue_idx_q == `ME_N_WORDS - 1) begin
                    issue_q <= 1'b0;
                end
            end
            if (!busy_q && xfer_req.kind != me_store_pkg::XFER_NONE) begin
                cur_q       <= xfer_req;
                busy_q      <= 1'b1;
                issue_q     <= 1'b1;
                issue_idx_q <= '0;
            end else if (rvalid_q && !issue_q) begin
                busy_q <= 1'b0;  // last word lands this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_q) begin
            mem_q <= mem[{cur_q.addr, issue_idx_q}];
        end
        if (rvalid_q && is_swap) begin
            mem[{unit_addr, ridx_q}] <= bank_rdata;  // address as held by the unit
        end
    end

    assign store_idle   = ~busy_q;
    assign bank_unit    = cur_q.unit;
    assign bank_idx     = is_swap ? issue_idx_q : ridx_q;
    assign bank_rden    = issue_q & is_swap;
    assign bank_wren    = rvalid_q & (is_copy | is_blank);
    assign bank_wdata   = is_blank ? me_store_pkg::res_word_t'(ridx_q == '0) : mem_q;
    assign stream_valid = rvalid_q & is_stream;
    assign stream_data  = mem_q;

endmodule

//--- me_unit_bank.sv
`timescale 1ns/1ps
`include "me_defines.svh"

module me_unit_bank (
    input  logic                        clk,
    input  logic                        ctrl_reset_n,
    input  me_store_pkg::unit_id_t      bank_unit,
    input  me_store_pkg::word_idx_t     bank_idx,
    input  logic                        bank_rden,
    input  logic                        bank_wren,
    input  me_store_pkg::res_word_t     bank_wdata,
    output me_store_pkg::res_word_t     bank_rdata,
    input  logic                        addr_wren,
    input  me_store_pkg::unit_id_t      addr_unit,
    input  me_store_pkg::store_addr_t   addr_data,
    output me_store_pkg::store_addr_t   unit_addr
);

    // one result buffer per unit, indexed {unit, word}
    me_store_pkg::res_word_t    buf_mem [`ME_N_UNITS * `ME_N_WORDS];
    me_store_pkg::store_addr_t  addr_q [`ME_N_UNITS];  // where each unit's result lives

    always_ff @(posedge clk) begin
        if (bank_wren) begin
            buf_mem[{bank_unit, bank_idx}] <= bank_wdata;
        end
        if (bank_rden) begin
            bank_rdata <= buf_mem[{bank_unit, bank_idx}];
        end
    end

    always_ff @(posedge clk or negedge ctrl_reset_n) begin
        if (~ctrl_reset_n) begin
            for (int i = 0; i < `ME_N_UNITS; i++) begin
                addr_q[i] <= '0;
            end
        end else if (addr_wren) begin
            addr_q[addr_unit] <= addr_data;
        end
    end

    assign unit_addr = addr_q[bank_unit];  // store looks this up during swap out

endmodule

//--- me_top.sv
`timescale 1ns/1ps
`include "me_defines.svh"

module me_top (
    input  logic                        clk,
    input  logic                        ctrl_reset_n,
    input  me_host_pkg::host_word_t     fifo_datai,
    input  logic                        fifo_empty,
    input  logic [`ME_FIFO_WIDTHU:0]    fifo_usedw_in,
    output logic                        fifo_rden,
    output me_host_pkg::host_word_t     fifo_datao,
    output logic                        fifo_wren,
    input  logic                        fifo_full,
    input  logic [`ME_FIFO_WIDTHU:0]    fifo_usedw_out
);

    me_store_pkg::xfer_req_t    xfer_req;
    me_store_pkg::res_word_t    stream_data;
    me_store_pkg::unit_id_t     addr_unit, bank_unit;
    me_store_pkg::store_addr_t  addr_data, unit_addr;
    me_store_pkg::word_idx_t    bank_idx;
    me_store_pkg::res_word_t    bank_wdata, bank_rdata;
    logic                       store_idle, stream_valid, addr_wren;
    logic                       bank_rden, bank_wren;

    me_command_engine u_engine (
        .clk            (clk),
        .ctrl_reset_n   (ctrl_reset_n),
        .fifo_datai     (fifo_datai),
        .fifo_empty     (fifo_empty),
        .fifo_usedw_in  (fifo_usedw_in),
        .fifo_rden      (fifo_rden),
        .fifo_datao     (fifo_datao),
        .fifo_wren      (fifo_wren),
        .fifo_full      (fifo_full),
        .fifo_usedw_out (fifo_usedw_out),
        .xfer_req       (xfer_req),
        .store_idle     (store_idle),
        .stream_data    (stream_data),
        .stream_valid   (stream_valid),
        .addr_wren      (addr_wren),
        .addr_unit      (addr_unit),
        .addr_data      (addr_data)
    );

    me_result_store u_store (
        .clk            (clk),
        .ctrl_reset_n   (ctrl_reset_n),
        .xfer_req       (xfer_req),
        .store_idle     (store_idle),
        .unit_addr      (unit_addr),
        .bank_unit      (bank_unit),
        .bank_idx       (bank_idx),
        .bank_rden      (bank_rden),
        .bank_wren      (bank_wren),
        .bank_wdata     (bank_wdata),
        .bank_rdata     (bank_rdata),
        .stream_data    (stream_data),
        .stream_valid   (stream_valid)
    );

    me_unit_bank u_bank (
        .clk            (clk),
        .ctrl_reset_n   (ctrl_reset_n),
        .bank_unit      (bank_unit),
        .bank_idx       (bank_idx),
        .bank_rden      (bank_rden),
        .bank_wren      (bank_wren),
        .bank_wdata     (bank_wdata),
        .bank_rdata     (bank_rdata),
        .addr_wren      (addr_wren),
        .addr_unit      (addr_unit),
        .addr_data      (addr_data),
        .unit_addr      (unit_addr)
    );

endmodule

//--- me_chk.sv
`timescale 1ns/1ps
`include "me_defines.svh"

module me_chk (
    input  logic                    clk,
    input  logic                    ctrl_reset_n,
    input  logic                    fifo_rden,
    input  logic                    fifo_wren,
    input  logic                    fifo_full,
    input  me_host_pkg::host_word_t fifo_datao
);

    int unsigned fail_cnt = 0;  // failed assertions so far

    logic [`ME_RSP_W-1:0] code;

    assign code = fifo_datao[`ME_WORD_W-1 -: `ME_RSP_W];

    // a pending word waits under full without changing
    property hold_under_full;
        @(posedge clk) disable iff (!ctrl_reset_n)
            fifo_wren && fifo_full |=> fifo_wren && $stable(fifo_datao);
    endproperty

    property no_rden_in_reset;
        @(posedge clk) !ctrl_reset_n |-> !fifo_rden;
    endproperty

    // stream words carry zeros in the code field
    property legal_code;
        @(posedge clk) disable iff (!ctrl_reset_n)
            fifo_wren && !fifo_full |->
                code inside {4'h0, `ME_RSP_ERAM, `ME_RSP_SETADDR, `ME_RSP_READ};
    endproperty

    a_hold_under_full: assert property (hold_under_full)
        else begin
            fail_cnt++;
            $error("write fifo word changed or dropped while fifo_full was high");
        end

    a_no_rden_in_reset: assert property (no_rden_in_reset)
        else begin
            fail_cnt++;
            $error("fifo_rden high while ctrl_reset_n was low");
        end

    a_legal_code: assert property (legal_code)
        else begin
            fail_cnt++;
            $error("accepted word has an illegal response code %h", code);
        end

endmodule

bind me_command_engine me_chk u_chk (
    .clk          (clk),
    .ctrl_reset_n (ctrl_reset_n),
    .fifo_rden    (fifo_rden),
    .fifo_wren    (fifo_wren),
    .fifo_full    (fifo_full),
    .fifo_datao   (fifo_datao)
);

//--- tb_me_top.sv
`timescale 1ns/1ps
`include "me_defines.svh"

module tb_me_top;

    localparam int N_CMDS       = 14;
    localparam int CMD_CYCLES   = 200;     // worst case sequence incl. full stalls
    localparam int TIMEOUT_NS   = (N_CMDS * CMD_CYCLES + 20) * 4;

    logic                           clk = 1'b0;
    logic                           ctrl_reset_n;
    me_host_pkg::host_word_t        fifo_datai;
    logic                           fifo_empty;
    logic [`ME_FIFO_WIDTHU:0]       fifo_usedw_in;
    logic                           fifo_rden;
    me_host_pkg::host_word_t        fifo_datao;
    logic                           fifo_wren;
    logic                           fifo_full;
    logic [`ME_FIFO_WIDTHU:0]       fifo_usedw_out;

    me_host_pkg::host_word_t        src_q[$];   // words waiting to enter the read fifo
    me_host_pkg::host_word_t        rq[$];      // read fifo contents
    me_host_pkg::host_word_t        exp_q[$];   // expected write fifo words
    logic [31:0]                    lfsr = 32'ha037_6c40;
    logic                           gappy = 1'b0;
    int                             full_mode = 0;   // 0 never, 1 random, 2 held
    int                             errors = 0;

    // mirror of the result store and the unit bank
    me_store_pkg::res_word_t        st_mem [16][`ME_N_WORDS];
    me_store_pkg::res_word_t        ubuf [`ME_N_UNITS][`ME_N_WORDS];
    me_store_pkg::store_addr_t      uaddr [`ME_N_UNITS];

    me_top dut (
        .clk            (clk),
        .ctrl_reset_n   (ctrl_reset_n),
        .fifo_datai     (fifo_datai),
        .fifo_empty     (fifo_empty),
        .fifo_usedw_in  (fifo_usedw_in),
        .fifo_rden      (fifo_rden),
        .fifo_datao     (fifo_datao),
        .fifo_wren      (fifo_wren),
        .fifo_full      (fifo_full),
        .fifo_usedw_out (fifo_usedw_out)
    );

    always #2 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic me_host_pkg::host_word_t make_cmd(logic [5:0] cmd, logic lp,
                                                        int unit, int addr);
        me_host_pkg::host_cmd_t c;
        c.cmd       = me_host_pkg::host_cmd_e'(cmd);
        c.load_prev = lp;
        c.unit      = 5'(unit);
        c.addr      = 20'(addr);
        return me_host_pkg::host_word_t'(c);
    endfunction

    // swap out, take the new address, preload
    task automatic send_addr_cmd(logic eram, int unit, logic lp, int addr);
        src_q.push_back(make_cmd(eram ? 6'b000001 : 6'b000010, lp, unit, addr));
        if (eram) begin
            for (int i = 0; i < `ME_E_WORDS; i++) begin
                src_q.push_back(32'hE000_0000 | i);   // payload, looks like no command
            end
        end
        for (int w = 0; w < `ME_N_WORDS; w++) begin
            st_mem[uaddr[unit]][w] = ubuf[unit][w];
        end
        uaddr[unit] = 4'(addr);
        for (int w = 0; w < `ME_N_WORDS; w++) begin
            ubuf[unit][w] = lp ? st_mem[addr][w] : 27'(w == 0);
        end
        exp_q.push_back({eram ? `ME_RSP_ERAM : `ME_RSP_SETADDR, 28'h0});
    endtask

    task automatic send_read(int addr);
        src_q.push_back(make_cmd(6'b001000, 1'b0, 0, addr));
        exp_q.push_back({`ME_RSP_READ, 8'(`ME_N_WORDS), 20'(addr)});
        for (int w = 0; w < `ME_N_WORDS; w++) begin
            exp_q.push_back({5'h0, st_mem[addr][w]});
        end
    endtask

    task automatic wait_drained();
        while (!(exp_q.size() == 0 && src_q.size() == 0 && rq.size() == 0 &&
                 fifo_rden && !fifo_wren)) begin
            @(negedge clk);
        end
    endtask

    task automatic check_word(me_host_pkg::host_word_t got);
        me_host_pkg::host_word_t want;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("Fail %0t: unexpected word %h written", $time, got);
        end
        if (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            assert (got === want) else begin
                errors++;
                $display("Fail %0t: write fifo got %h, expected %h", $time, got, want);
            end
        end
    endtask

    // fifo models, both sides
    always @(posedge clk) begin
        if (fifo_rden && !fifo_empty) begin
            fifo_datai <= rq.pop_front();
        end
        if (src_q.size() > 0 && !(gappy && lfsr_bit())) begin
            rq.push_back(src_q.pop_front());
        end
        fifo_empty    <= (rq.size() == 0);
        fifo_usedw_in <= 6'(rq.size());
        if (fifo_wren && !fifo_full) begin
            check_word(fifo_datao);
        end
        case (full_mode)
            1:       fifo_full <= lfsr_bit();
            2:       fifo_full <= 1'b1;
            default: fifo_full <= 1'b0;
        endcase
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the command sequence in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int total;
        ctrl_reset_n   = 1'b0;
        fifo_datai     = '0;
        fifo_empty     = 1'b1;
        fifo_usedw_in  = '0;
        fifo_full      = 1'b0;
        fifo_usedw_out = '0;
        for (int u = 0; u < `ME_N_UNITS; u++) begin
            uaddr[u] = '0;
        end
        repeat (4) @(posedge clk);
        ctrl_reset_n <= 1'b1;

        for (int i = 0; i < 8; i++) begin   // nothing written before a command
            @(negedge clk);
            assert (!fifo_wren) else begin
                errors++;
                $display("Fail %0t: fifo_wren high before any command", $time);
            end
        end

        send_addr_cmd(1'b1, 0, 1'b0, 3);
        send_addr_cmd(1'b0, 0, 1'b0, 5);
        wait_drained();
        send_read(3);
        wait_drained();

        full_mode = 1;   // random back-pressure on the responses
        send_addr_cmd(1'b1, 1, 1'b1, 3);
        send_addr_cmd(1'b0, 1, 1'b0, 9);
        wait_drained();
        full_mode = 0;
        send_read(3);
        wait_drained();

        src_q.push_back(make_cmd(6'b010000, 1'b0, 2, 4));   // unknown code
        src_q.push_back(make_cmd(6'b000100, 1'b0, 2, 4));   // dropped LOAD_TRAM
        send_addr_cmd(1'b0, 2, 1'b0, 7);
        wait_drained();
        send_read(3);
        wait_drained();

        full_mode = 2;
        send_addr_cmd(1'b0, 0, 1'b0, 11);
        while (!fifo_wren) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        full_mode = 0;
        wait_drained();

        gappy = 1'b1;
        send_addr_cmd(1'b1, 3, 1'b0, 2);
        send_read(5);
        wait_drained();
        gappy = 1'b0;
        repeat (4) @(negedge clk);

        total = errors + dut.u_engine.u_chk.fail_cnt;
        $display("errors: scoreboard %0d, assertions %0d", errors,
                 dut.u_engine.u_chk.fail_cnt);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
me_host_pkg.sv
me_store_pkg.sv
me_command_engine.sv
me_result_store.sv
me_unit_bank.sv
me_top.sv
me_chk.sv
tb_me_top.sv
